/* Makefile */
SIM        = verilator
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = gf4_elim_tb
FLIST      = flist.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Done: errors found
PASS_MSG   = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/gf4_elim_model.svh */
`ifndef GF4_ELIM_MODEL_SVH
`define GF4_ELIM_MODEL_SVH

//////////////////////////////
// GF(4) reference arithmetic
//////////////////////////////

// nonzero elements are the powers of x
function automatic int field_log(gf_elem_t a);
  case (a)
    2'd1:    return 0;
    2'd2:    return 1;
    default: return 2;
  endcase
endfunction

function automatic gf_elem_t field_exp(int e);
  case (e % 3)
    0:       return 2'd1;
    1:       return 2'd2;
    default: return 2'd3;
  endcase
endfunction

function automatic gf_elem_t field_mul(gf_elem_t a, gf_elem_t b);
  if (a == 2'd0 || b == 2'd0) begin
    return 2'd0;
  end
  return field_exp(field_log(a) + field_log(b));
endfunction

function automatic gf_elem_t field_inv(gf_elem_t a);
  return field_exp(3 - field_log(a));
endfunction

//////////////////////////////
// elimination model
//////////////////////////////

row_t model_piv  [n_dim];
bit   model_held [n_dim];

function automatic void model_clear();
  for (int i = 0; i < n_dim; i++) begin
    model_piv[i]  = '0;
    model_held[i] = 1'b0;
  end
endfunction

function automatic bit model_full_rank();
  bit all_held;
  all_held = 1'b1;
  for (int i = 0; i < n_dim; i++) begin
    all_held &= model_held[i];
  end
  return all_held;
endfunction

// one row through pivots 0 to n_dim-1
task automatic model_push(input row_t row_m, output bit residual, output row_t reduced);
  row_t     r;
  gf_elem_t e;
  r        = row_m;
  residual = 1'b1;
  for (int i = 0; i < n_dim && residual; i++) begin
    e = r[i];
    if (model_held[i]) begin
      for (int j = 0; j < n_dim; j++) begin
        r[j] = r[j] ^ field_mul(e, model_piv[i][j]);
      end
    end else if (e != 2'd0) begin
      for (int j = 0; j < n_dim; j++) begin
        model_piv[i][j] = field_mul(r[j], field_inv(e));
      end
      model_held[i] = 1'b1;
      residual      = 1'b0;
    end
  end
  reduced = r;
endtask

function automatic row_t make_row(gf_elem_t e0, gf_elem_t e1, gf_elem_t e2, gf_elem_t e3);
  return {e3, e2, e1, e0};
endfunction

//////////////////////////////
// directed tests
//////////////////////////////

task automatic test_identity();
  row_t rows [$];
  apply_reset();
  for (int i = 0; i < n_dim; i++) begin
    rows.push_back(row_t'(8'h1 << (2 * i)));
  end
  stream_rows(rows);
  check_value("full_rank", 32'(full_rank), 32'd1);
  unload_check();
endtask

task automatic test_random_full_rank();
  row_t rows [$];
  int   tries;
  bit   residual;
  row_t reduced;
  apply_reset();
  tries = 0;
  do begin
    rows.delete();
    model_clear();
    for (int k = 0; k < n_dim; k++) begin
      rows.push_back(row_t'($random(seed)));
      model_push(rows[k], residual, reduced);
    end
    tries++;
  end while (!model_full_rank() && tries < 100);
  if (!model_full_rank()) begin
    n_errors++;
    $display("no full-rank random matrix found after %0d draws", tries);
  end
  model_clear();
  // extra rows after the matrix reduce to zero
  rows.push_back(row_t'($random(seed)));
  rows.push_back(row_t'($random(seed)));
  stream_rows(rows);
  unload_check();
endtask

task automatic test_rank_deficient();
  row_t rows [$];
  apply_reset();
  rows.push_back(make_row(2'd1, 2'd2, 2'd0, 2'd3));
  rows.push_back(make_row(2'd0, 2'd1, 2'd3, 2'd2));
  rows.push_back(make_row(2'd1, 2'd2, 2'd0, 2'd3));
  rows.push_back(make_row(2'd0, 2'd0, 2'd1, 2'd1));
  stream_rows(rows);
  check_value("full_rank", 32'(full_rank), 32'd0);
  unload_check();
endtask

task automatic test_zero_column();
  row_t rows [$];
  apply_reset();
  // first row skips pivot 0
  rows.push_back(make_row(2'd0, 2'd2, 2'd1, 2'd3));
  rows.push_back(make_row(2'd3, 2'd1, 2'd0, 2'd2));
  rows.push_back(make_row(2'd0, 2'd0, 2'd2, 2'd1));
  rows.push_back(make_row(2'd1, 2'd1, 2'd1, 2'd1));
  stream_rows(rows);
  unload_check();
endtask

task automatic test_reset_between();
  row_t rows [$];
  apply_reset();
  rows.push_back(make_row(2'd2, 2'd1, 2'd0, 2'd0));
  rows.push_back(make_row(2'd0, 2'd3, 2'd1, 2'd0));
  rows.push_back(make_row(2'd0, 2'd0, 2'd2, 2'd1));
  rows.push_back(make_row(2'd0, 2'd0, 2'd0, 2'd3));
  stream_rows(rows);
  // reset lands mid-unload with a row still in flight
  finish    = 1'b1;
  row_valid = 1'b1;
  row_in    = make_row(2'd2, 2'd1, 2'd0, 2'd0);
  repeat (unload_latency) begin
    @(posedge clk);
    #1;
    finish    = 1'b0;
    row_valid = 1'b0;
  end
  check_value("piv_valid", 32'(piv_valid), 32'd1);
  apply_reset();
  check_value("res_valid", 32'(res_valid), 32'd0);
  check_value("piv_valid", 32'(piv_valid), 32'd0);
  check_value("full_rank", 32'(full_rank), 32'd0);
  // second stream leaves pivots 2 and 3 empty
  rows.delete();
  rows.push_back(make_row(2'd0, 2'd1, 2'd2, 2'd3));
  rows.push_back(make_row(2'd0, 2'd2, 2'd3, 2'd1));
  rows.push_back(make_row(2'd3, 2'd0, 2'd0, 2'd1));
  stream_rows(rows);
  unload_check();
endtask

`endif

/* dv/gf4_elim_tb.sv */
module gf4_elim_tb import gf4_elim_pkg::*; ();

  logic clk;
  logic reset;
  logic row_valid;
  row_t row_in;
  logic finish;
  logic res_valid;
  row_t res_row;
  logic piv_valid;
  row_t piv_row;
  logic full_rank;

  int n_errors;
  int n_checks;
  int seed;

  gf4_elim_top u_gf4_elim_top (
    .clk       (clk),
    .reset     (reset),
    .row_valid (row_valid),
    .row_in    (row_in),
    .finish    (finish),
    .res_valid (res_valid),
    .res_row   (res_row),
    .piv_valid (piv_valid),
    .piv_row   (piv_row),
    .full_rank (full_rank)
  );

  always #5 clk = ~clk;

  `include "gf4_elim_model.svh"

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    n_checks++;
    if (got !== expected) begin
      n_errors++;
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, expected);
    end
  endtask

  task automatic apply_reset();
    reset     = 1'b1;
    row_valid = 1'b0;
    row_in    = '0;
    finish    = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    model_clear();
  endtask

  //////////////////////////////
  // stimulus and response
  //////////////////////////////

  // rows back to back, each residual slot checked at res_latency
  task automatic stream_rows(input row_t rows [$]);
    bit   exp_res [$];
    row_t exp_row [$];
    bit   residual;
    row_t reduced;
    int   slot;
    foreach (rows[k]) begin
      model_push(rows[k], residual, reduced);
      exp_res.push_back(residual);
      exp_row.push_back(reduced);
    end
    for (int c = 0; c < rows.size() + res_latency; c++) begin
      @(posedge clk);
      #1;
      slot = c - res_latency;
      if (slot >= 0) begin
        check_value("res_valid", 32'(res_valid), 32'(exp_res[slot]));
        if (exp_res[slot]) begin
          check_value("res_row", 32'(res_row), 32'(exp_row[slot]));
        end
      end else begin
        check_value("res_valid", 32'(res_valid), 32'd0);
      end
      row_valid = (c < rows.size());
      row_in    = (c < rows.size()) ? rows[c] : '0;
    end
    check_value("full_rank", 32'(full_rank), 32'(model_full_rank()));
  endtask

  task automatic unload_check();
    int waited;
    finish = 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      #1;
      finish = 1'b0;
      waited++;
    end while (!piv_valid && waited < 2 * res_latency);
    if (!piv_valid) begin
      n_errors++;
      $display("unload never started, piv_valid stayed low after finish");
    end else begin
      check_value("unload_latency", 32'(waited), 32'(unload_latency));
      for (int i = 0; i < n_dim; i++) begin
        if (i > 0) begin
          @(posedge clk);
          #1;
        end
        check_value("piv_valid", 32'(piv_valid), 32'd1);
        check_value($sformatf("piv_row[%0d]", i), 32'(piv_row), 32'(model_piv[i]));
      end
      @(posedge clk);
      #1;
      check_value("piv_valid", 32'(piv_valid), 32'd0);
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    row_valid = 1'b0;
    row_in    = '0;
    finish    = 1'b0;
    n_errors  = 0;
    n_checks  = 0;
    seed      = 32'h77a9422a;
    test_identity();
    test_random_full_rank();
    test_rank_deficient();
    test_zero_column();
    test_reset_between();
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+dv
verilog/gf4_elim_pkg.sv
verilog/skew_buffer.sv
verilog/pivot_cell.sv
verilog/elim_cell.sv
verilog/elim_array.sv
verilog/elim_ctrl.sv
verilog/gf4_elim_top.sv
dv/gf4_elim_tb.sv

/* verilog/elim_array.sv */
module elim_array import gf4_elim_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  cell_data_t [n_dim-1:0] top_cols,
  output cell_data_t [n_dim-1:0] bottom_cols,
  output logic [n_dim-1:0]       piv_held,
  output row_t [n_dim-1:0]       stored_rows
);

  // per-cell nets
  cell_data_t cell_din    [n_dim][n_dim];
  cell_data_t cell_dout   [n_dim][n_dim];
  cell_op_t   cell_oout   [n_dim][n_dim];
  gf_elem_t   cell_stored [n_dim][n_dim];
  logic       cell_held   [n_dim];

  // registered links, data down and ops right
  cell_data_t [n_dim-1:0][n_dim-1:0] data_link;
  cell_op_t   [n_dim-1:0][n_dim-1:1] op_link;

  //////////////////////////////
  // cell grid
  //////////////////////////////

  for (genvar i = 0; i < n_dim; i++) begin : g_row
    for (genvar j = 0; j < n_dim; j++) begin : g_col
      if (i == 0) begin : g_top
        assign cell_din[i][j] = top_cols[j];
      end else begin : g_inner
        assign cell_din[i][j] = data_link[i-1][j];
      end

      if (j == i) begin : g_piv
        pivot_cell u_piv (
          .clk      (clk),
          .reset    (reset),
          .data_in  (cell_din[i][j]),
          .data_out (cell_dout[i][j]),
          .op_out   (cell_oout[i][j]),
          .held     (cell_held[i]),
          .stored   (cell_stored[i][j])
        );
      end else begin : g_elim
        cell_op_t op_in;

        // left of the diagonal only zeros or absorbed rows go by
        if (j < i) begin : g_left
          assign op_in = '{op: OP_NONE, fac: '0};
        end else begin : g_right
          assign op_in = op_link[i][j];
        end

        elim_cell u_elim (
          .clk      (clk),
          .reset    (reset),
          .data_in  (cell_din[i][j]),
          .op_in    (op_in),
          .data_out (cell_dout[i][j]),
          .op_out   (cell_oout[i][j]),
          .stored   (cell_stored[i][j])
        );
      end
    end
  end

  //////////////////////////////
  // link registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    for (int i = 0; i < n_dim; i++) begin
      for (int j = 0; j < n_dim; j++) begin
        data_link[i][j] <= cell_dout[i][j];
        if (j > 0) begin
          op_link[i][j] <= cell_oout[i][j-1];
        end
      end
    end
    if (reset) begin
      for (int i = 0; i < n_dim; i++) begin
        for (int j = 0; j < n_dim; j++) begin
          data_link[i][j].valid <= 1'b0;
          if (j > 0) begin
            op_link[i][j].op <= OP_NONE;
          end
        end
      end
    end
  end

  assign bottom_cols = data_link[n_dim-1];

  always_comb begin
    for (int i = 0; i < n_dim; i++) begin
      piv_held[i] = cell_held[i];
      for (int j = 0; j < n_dim; j++) begin
        stored_rows[i][j] = cell_stored[i][j];
      end
    end
  end

endmodule

/* verilog/elim_cell.sv */
module elim_cell import gf4_elim_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  cell_data_t data_in,
  input  cell_op_t   op_in,
  output cell_data_t data_out,
  output cell_op_t   op_out,
  output gf_elem_t   stored
);

  // scaled pivot row element
  always_ff @(posedge clk) begin
    if (reset) begin
      stored <= '0;
    end else if (op_in.op == OP_STORE) begin
      stored <= gf_mul(data_in.elem, op_in.fac);
    end
  end

  always_comb begin
    data_out = data_in;
    case (op_in.op)
      OP_STORE: data_out.valid = 1'b0;
      OP_ELIM:  data_out.elem  = gf_add(data_in.elem, gf_mul(op_in.fac, stored));
      default:  data_out = data_in;
    endcase
  end

  // next column picks this up through its link register
  assign op_out = op_in;

endmodule

/* verilog/elim_ctrl.sv */
module elim_ctrl import gf4_elim_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   row_valid,
  input  row_t                   row_in,
  input  logic                   finish,
  input  cell_data_t [n_dim-1:0] out_cols,
  input  logic [n_dim-1:0]       piv_held,
  input  row_t [n_dim-1:0]       stored_rows,
  output cell_data_t [n_dim-1:0] in_cols,
  output logic                   res_valid,
  output row_t                   res_row,
  output logic                   piv_valid,
  output row_t                   piv_row,
  output logic                   full_rank
);

  typedef enum logic {
    IDLE,
    UNLOAD
  } ctrl_state_e;

  logic             in_valid_q;
  row_t             in_row_q;
  ctrl_state_e      state;
  logic [cnt_w-1:0] row_cnt;

  //////////////////////////////
  // input side
  //////////////////////////////

  always_ff @(posedge clk) begin
    in_row_q <= row_in;
    if (reset) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= row_valid;
    end
  end

  always_comb begin
    for (int j = 0; j < n_dim; j++) begin
      in_cols[j].valid = in_valid_q;
      in_cols[j].elem  = in_row_q[j];
    end
  end

  //////////////////////////////
  // residual side
  //////////////////////////////

  // the last column is dropped by whichever pivot absorbs the row,
  // lower columns can still carry a stale valid
  always_ff @(posedge clk) begin
    for (int j = 0; j < n_dim; j++) begin
      res_row[j] <= out_cols[j].elem;
    end
    if (reset) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= out_cols[n_dim-1].valid;
    end
  end

  //////////////////////////////
  // unload FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      row_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (finish) begin
            state   <= UNLOAD;
            row_cnt <= '0;
          end
        end
        UNLOAD: begin
          row_cnt <= row_cnt + 1'b1;
          if (row_cnt == cnt_w'(n_dim - 1)) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    piv_row <= stored_rows[row_cnt];
    if (reset) begin
      piv_valid <= 1'b0;
      full_rank <= 1'b0;
    end else begin
      piv_valid <= (state == UNLOAD);
      full_rank <= &piv_held;
    end
  end

  a_no_finish_in_unload: assert property (
    @(posedge clk) disable iff (reset) state == UNLOAD |-> !finish
  );

  // first pivot row lands a fixed time after finish
  a_unload_start: assert property (
    @(posedge clk) disable iff (reset)
    finish && state == IDLE |-> ##unload_latency piv_valid
  );

endmodule

/* verilog/gf4_elim_pkg.sv */
package gf4_elim_pkg;

  //////////////////////////////
  // array geometry and latencies
  //////////////////////////////

  localparam int n_dim = 4;
  localparam int cnt_w = $clog2(n_dim);

  // in reg, n_dim array rows, n_dim-1 deskew stages, out reg
  localparam int res_latency = 2 * n_dim + 1;

  // finish to first pivot row on piv_row
  localparam int unload_latency = 2;

  //////////////////////////////
  // types
  //////////////////////////////

  // GF(2^2), field polynomial x^2 + x + 1
  typedef logic [1:0] gf_elem_t;

  // element 0 sits in the low bits
  typedef gf_elem_t [n_dim-1:0] row_t;

  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_PASS  = 2'd1,
    OP_STORE = 2'd2,
    OP_ELIM  = 2'd3
  } op_e;

  // horizontal link
  typedef struct packed {
    op_e      op;
    gf_elem_t fac;
  } cell_op_t;

  // vertical link
  typedef struct packed {
    logic     valid;
    gf_elem_t elem;
  } cell_data_t;

  //////////////////////////////
  // arithmetic
  //////////////////////////////

  function automatic gf_elem_t gf_add(gf_elem_t a, gf_elem_t b);
    return a ^ b;
  endfunction

  function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
    gf_elem_t p;
    // x^2 folds back as x + 1
    p[0] = (a[0] & b[0]) ^ (a[1] & b[1]);
    p[1] = (a[1] & b[0]) ^ (a[0] & b[1]) ^ (a[1] & b[1]);
    return p;
  endfunction

  // inverse is a^2 here, 0 maps to 0 but is never asked for
  function automatic gf_elem_t gf_inv(gf_elem_t a);
    return {a[1], a[1] ^ a[0]};
  endfunction

  // shift depth of one skew column
  function automatic int skew_depth(bit reverse, int col);
    return reverse ? n_dim - 1 - col : col;
  endfunction

endpackage

/* verilog/gf4_elim_top.sv */
module gf4_elim_top import gf4_elim_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic row_valid,
  input  row_t row_in,
  input  logic finish,
  output logic res_valid,
  output row_t res_row,
  output logic piv_valid,
  output row_t piv_row,
  output logic full_rank
);

  cell_data_t [n_dim-1:0] in_cols;
  cell_data_t [n_dim-1:0] skew_cols;
  cell_data_t [n_dim-1:0] bottom_cols;
  cell_data_t [n_dim-1:0] out_cols;
  logic [n_dim-1:0]       piv_held;
  row_t [n_dim-1:0]       stored_rows;

  elim_ctrl u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .row_valid   (row_valid),
    .row_in      (row_in),
    .finish      (finish),
    .out_cols    (out_cols),
    .piv_held    (piv_held),
    .stored_rows (stored_rows),
    .in_cols     (in_cols),
    .res_valid   (res_valid),
    .res_row     (res_row),
    .piv_valid   (piv_valid),
    .piv_row     (piv_row),
    .full_rank   (full_rank)
  );

  // column j enters j cycles late
  skew_buffer #(.reverse(1'b0)) u_skew_in (
    .clk      (clk),
    .reset    (reset),
    .cols_in  (in_cols),
    .cols_out (skew_cols)
  );

  elim_array u_array (
    .clk         (clk),
    .reset       (reset),
    .top_cols    (skew_cols),
    .bottom_cols (bottom_cols),
    .piv_held    (piv_held),
    .stored_rows (stored_rows)
  );

  // realign the bottom columns
  skew_buffer #(.reverse(1'b1)) u_skew_out (
    .clk      (clk),
    .reset    (reset),
    .cols_in  (bottom_cols),
    .cols_out (out_cols)
  );

endmodule

/* verilog/pivot_cell.sv */
module pivot_cell import gf4_elim_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  cell_data_t data_in,
  output cell_data_t data_out,
  output cell_op_t   op_out,
  output logic       held,
  output gf_elem_t   stored
);

  typedef enum logic {
    EMPTY,
    HELD
  } piv_state_e;

  piv_state_e state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= EMPTY;
    end else if (state == EMPTY && data_in.valid && data_in.elem != '0) begin
      state <= HELD;
    end
  end

  always_comb begin
    op_out   = '{op: OP_NONE, fac: '0};
    data_out = data_in;
    if (data_in.valid) begin
      if (state == HELD) begin
        // factor is the element itself, the pivot column cancels to zero
        op_out        = '{op: OP_ELIM, fac: data_in.elem};
        data_out.elem = '0;
      end else if (data_in.elem != '0) begin
        // row is absorbed here
        op_out         = '{op: OP_STORE, fac: gf_inv(data_in.elem)};
        data_out.valid = 1'b0;
      end else begin
        op_out.op = OP_PASS;
      end
    end
  end

  assign held = (state == HELD);

  // normalized pivot row has 1 on the diagonal
  assign stored = gf_elem_t'(held);

  a_store_once: assert property (
    @(posedge clk) disable iff (reset)
    op_out.op == OP_STORE |-> !held ##1 held
  );

endmodule

/* verilog/skew_buffer.sv */
module skew_buffer import gf4_elim_pkg::*; #(
  parameter bit reverse = 1'b0
) (
  input  logic                   clk,
  input  logic                   reset,
  input  cell_data_t [n_dim-1:0] cols_in,
  output cell_data_t [n_dim-1:0] cols_out
);

  for (genvar j = 0; j < n_dim; j++) begin : g_col
    if (skew_depth(reverse, j) == 0) begin : g_direct
      assign cols_out[j] = cols_in[j];
    end else begin : g_shift
      cell_data_t [skew_depth(reverse, j)-1:0] pipe;

      always_ff @(posedge clk) begin
        pipe[0] <= cols_in[j];
        for (int k = 1; k < skew_depth(reverse, j); k++) begin
          pipe[k] <= pipe[k-1];
        end
        // drop any row in flight
        if (reset) begin
          for (int k = 0; k < skew_depth(reverse, j); k++) begin
            pipe[k].valid <= 1'b0;
          end
        end
      end

      assign cols_out[j] = pipe[skew_depth(reverse, j)-1];
    end
  end

endmodule
